// File: hdl/grad_pkg.sv
`default_nettype none

package grad_pkg;

    localparam int pix_w = 8;   // pixel width
    localparam int mag_f = 4;   // magnitude fraction bits
    localparam int tan_i = 4;   // tan integer bits, sign included
    localparam int tan_f = 16;  // tan fraction bits

    localparam int mag_w = pix_w + 1 + mag_f;  // 9 integer + 4 fraction
    localparam int tan_w = tan_i + tan_f;      // Q4.16

    typedef logic        [pix_w-1:0]   pix_t;
    typedef logic signed [pix_w:0]     diff_t;   // bot - top, right - left
    typedef logic        [2*pix_w:0]   sumsq_t;  // sum of two squares
    typedef logic        [mag_w-1:0]   mag_t;
    typedef logic signed [tan_w-1:0]   tan_t;

    typedef struct packed {
        pix_t top;
        pix_t bot;
        pix_t left;
        pix_t right;
    } cross_t;

    typedef struct packed {
        mag_t mag;
        tan_t tan;
    } grad_result_t;

    localparam int fifo_depth = 16;

    typedef logic [4:0]  level_t;  // 0..fifo_depth
    typedef logic [15:0] count_t;

    // wishbone word addresses
    localparam logic [1:0] reg_status = 2'd0;
    localparam logic [1:0] reg_mag    = 2'd1;
    localparam logic [1:0] reg_tan    = 2'd2;
    localparam logic [1:0] reg_counts = 2'd3;

    typedef enum logic {
        bus_idle,
        bus_ack
    } bus_state_t;

endpackage

`default_nettype wire

// File: hdl/sum_sq_diff.sv
`default_nettype none

module sum_sq_diff (
    input  wire                    clk,
    input  wire grad_pkg::cross_t  pix,
    output grad_pkg::diff_t        ver_diff,  // bot - top
    output grad_pkg::diff_t        hor_diff,  // right - left
    output grad_pkg::sumsq_t       result
);
    import grad_pkg::*;

    logic [2*pix_w-1:0] sq_ver;  // 255^2 still fits in 16 bits
    logic [2*pix_w-1:0] sq_hor;

    // stage 1, pixels are unsigned so extend with a zero
    always_ff @(posedge clk) begin
        ver_diff <= diff_t'({1'b0, pix.bot}) - diff_t'({1'b0, pix.top});
        hor_diff <= diff_t'({1'b0, pix.right}) - diff_t'({1'b0, pix.left});
    end

    // stage 2, signed square in 16-bit context
    always_ff @(posedge clk) begin
        sq_ver <= ver_diff * ver_diff;
        sq_hor <= hor_diff * hor_diff;
    end

    // stage 3
    always_ff @(posedge clk) begin
        result <= {1'b0, sq_ver} + {1'b0, sq_hor};
    end

endmodule

`default_nettype wire

// File: hdl/isqrt.sv
`default_nettype none

module isqrt (
    input  wire                    clk,
    input  wire grad_pkg::sumsq_t  radicand,
    output grad_pkg::mag_t         root
);
    import grad_pkg::*;

    // per-stage state, the last stage only keeps its root
    logic [2*mag_w-1:0] rad_q  [mag_w-1];  // bit pairs still to consume
    logic [mag_w+2:0]   rem_q  [mag_w-1];
    logic [mag_w-1:0]   root_q [mag_w];

    for (genvar i = 0; i < mag_w; i++) begin : g_stage
        logic [2*mag_w-1:0] rad_in;
        logic [mag_w+2:0]   rem_in;
        logic [mag_w-1:0]   root_in;
        logic [mag_w+2:0]   cand;
        logic [mag_w+1:0]   trial;

        if (i == 0) begin : g_first
            // fraction bits come from scaling the radicand by 4^mag_f
            assign rad_in  = (2*mag_w)'(radicand) << (2*mag_f);
            assign rem_in  = '0;
            assign root_in = '0;
        end else begin : g_next
            assign rad_in  = rad_q[i-1];
            assign rem_in  = rem_q[i-1];
            assign root_in = root_q[i-1];
        end

        // remainder stays below 2*root+1, so its low bits are enough
        assign cand  = {rem_in[mag_w:0], rad_in[2*mag_w-1 -: 2]};
        assign trial = {root_in, 2'b01};

        always_ff @(posedge clk) begin
            if (cand >= {1'b0, trial}) begin
                root_q[i] <= {root_in[mag_w-2:0], 1'b1};
            end else begin
                root_q[i] <= {root_in[mag_w-2:0], 1'b0};
            end
        end

        if (i < mag_w - 1) begin : g_carry
            always_ff @(posedge clk) begin
                rad_q[i] <= rad_in << 2;
                if (cand >= {1'b0, trial}) begin
                    rem_q[i] <= cand - {1'b0, trial};  // restore skipped
                end else begin
                    rem_q[i] <= cand;
                end
            end
        end
    end

    assign root = root_q[mag_w-1];

endmodule

`default_nettype wire

// File: hdl/tan_div.sv
`default_nettype none

module tan_div (
    input  wire                   clk,
    input  wire grad_pkg::diff_t  num,
    input  wire grad_pkg::diff_t  den,
    output grad_pkg::tan_t        quot
);
    import grad_pkg::*;

    logic [pix_w:0]       num_abs;
    logic [pix_w:0]       den_abs;
    logic                 neg_s1;
    logic [pix_w+tan_f:0] quo_abs;  // 25 bits, before saturation
    logic                 neg_s2;

    // stage 1 magnitudes and result sign
    always_ff @(posedge clk) begin
        num_abs <= num[pix_w] ? -num : num;
        den_abs <= den[pix_w] ? -den : den;
        neg_s1  <= num[pix_w] ^ den[pix_w];  // den of zero leaves sign of num
    end

    // stage 2 unsigned divide, truncates toward zero
    always_ff @(posedge clk) begin
        neg_s2 <= neg_s1;
        if (den_abs == '0) begin
            quo_abs <= (num_abs == '0) ? '0 : '1;  // forces saturation
        end else begin
            quo_abs <= {num_abs, {tan_f{1'b0}}} / den_abs;
        end
    end

    // stage 3 sign and clamp to Q4.16
    always_ff @(posedge clk) begin
        if (neg_s2) begin
            if (quo_abs >= (1 << (tan_w - 1))) begin
                quot <= {1'b1, {(tan_w-1){1'b0}}};
            end else begin
                quot <= -tan_t'(quo_abs);
            end
        end else begin
            if (quo_abs > {(tan_w-1){1'b1}}) begin
                quot <= {1'b0, {(tan_w-1){1'b1}}};
            end else begin
                quot <= tan_t'(quo_abs);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/mag_cal.sv
`default_nettype none

module mag_cal (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    input  wire grad_pkg::cross_t  pix,
    output logic                   res_valid,
    output grad_pkg::grad_result_t res
);
    import grad_pkg::*;

    diff_t  ver_diff;
    diff_t  hor_diff;
    sumsq_t sum_sq;
    mag_t   mag;
    tan_t   tan_raw;
    tan_t   tan_dly [12];  // divider is 1+3 deep, sqrt path 3+13
    logic [15:0] valid_sr;  // one bit per pipeline cycle

    // diffs after 1 cycle, sum after 3
    sum_sq_diff u_sum_sq_diff (
        .clk      (clk),
        .pix      (pix),
        .ver_diff (ver_diff),
        .hor_diff (hor_diff),
        .result   (sum_sq)
    );

    // 13 more cycles, 16 in total
    isqrt u_isqrt (
        .clk      (clk),
        .radicand (sum_sq),
        .root     (mag)
    );

    tan_div u_tan_div (
        .clk  (clk),
        .num  (ver_diff),
        .den  (hor_diff),
        .quot (tan_raw)
    );

    // line tan up with the magnitude
    always_ff @(posedge clk) begin
        tan_dly[0] <= tan_raw;
        for (int i = 1; i < 12; i++) begin
            tan_dly[i] <= tan_dly[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[14:0], in_valid};
        end
    end

    assign res_valid = valid_sr[15];
    assign res.mag   = mag;
    assign res.tan   = tan_dly[11];

endmodule

`default_nettype wire

// File: hdl/result_fifo.sv
`default_nettype none

module result_fifo (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          push,
    input  wire grad_pkg::grad_result_t  din,
    input  wire                          pop,
    input  wire                          clear_ovf,
    output grad_pkg::grad_result_t       head,
    output grad_pkg::level_t             level,
    output logic                         overflow,  // sticky
    output logic                         kept,
    output logic                         dropped
);
    import grad_pkg::*;

    grad_result_t mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic full;
    logic do_push;
    logic do_pop;

    assign full    = (level == level_t'(fifo_depth));
    assign do_push = push && !full;     // a pop in the same cycle does not make room
    assign do_pop  = pop && (level != '0);
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
            kept     <= 1'b0;
            dropped  <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            level   <= level + level_t'(do_push) - level_t'(do_pop);
            kept    <= do_push;
            dropped <= push && full;
            // a drop in the clearing cycle still sets the flag
            if (push && full) begin
                overflow <= 1'b1;
            end else if (clear_ovf) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/event_counter.sv
`default_nettype none

module event_counter (
    input  wire              clk,
    input  wire              rst,
    input  wire              kept,
    input  wire              dropped,
    input  wire              clear,
    output grad_pkg::count_t kept_cnt,
    output grad_pkg::count_t dropped_cnt
);

    always_ff @(posedge clk) begin
        if (!rst || clear) begin
            kept_cnt    <= '0;
            dropped_cnt <= '0;
        end else begin
            if (kept && kept_cnt != '1) kept_cnt <= kept_cnt + 1'b1;  // sticks at max
            if (dropped && dropped_cnt != '1) dropped_cnt <= dropped_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/wb_regs_ctrl.sv
`default_nettype none

module wb_regs_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cyc,
    input  wire                          stb,
    input  wire                          we,
    input  wire [1:0]                    adr,
    input  wire [31:0]                   dat_i,
    output logic [31:0]                  dat_o,
    output logic                         ack,
    input  wire grad_pkg::grad_result_t  head,
    input  wire grad_pkg::level_t        level,
    input  wire                          overflow,
    input  wire grad_pkg::count_t        kept_cnt,
    input  wire grad_pkg::count_t        dropped_cnt,
    output logic                         pop,
    output logic                         clear
);
    import grad_pkg::*;

    bus_state_t  state;
    logic        req;
    logic        empty;
    logic [31:0] rd_data;

    assign req   = (state == bus_idle) && cyc && stb;
    assign empty = (level == '0);
    assign ack   = (state == bus_ack);  // one cycle after the request

    // read mux, head fields read as zero on an empty queue
    always_comb begin
        case (adr)
            reg_status: rd_data = {23'd0, overflow, 3'd0, level};
            reg_mag:    rd_data = empty ? '0 : 32'(head.mag);
            reg_tan: begin
                rd_data = empty ? '0 : {{(32-tan_w){head.tan[tan_w-1]}}, head.tan};
            end
            default:    rd_data = {dropped_cnt, kept_cnt};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= bus_idle;
            pop   <= 1'b0;
            clear <= 1'b0;
        end else begin
            pop   <= 1'b0;
            clear <= 1'b0;
            case (state)
                bus_idle: begin
                    if (cyc && stb) begin
                        state <= bus_ack;
                        if (we) begin
                            clear <= (adr == reg_status);  // other writes ignored
                        end else begin
                            pop <= (adr == reg_tan) && !empty;
                        end
                    end
                end
                bus_ack: state <= bus_idle;
                default: state <= bus_idle;
            endcase
        end
    end

    // data held until the next access
    always_ff @(posedge clk) begin
        if (req) begin
            dat_o <= we ? dat_i : rd_data;  // write data echoed back, master ignores it
        end
    end

endmodule

`default_nettype wire

// File: hdl/grad_top.sv
`default_nettype none

module grad_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    input  wire grad_pkg::cross_t  in_pix,
    input  wire                    cyc,
    input  wire                    stb,
    input  wire                    we,
    input  wire [1:0]              adr,
    input  wire [31:0]             dat_i,
    output logic [31:0]            dat_o,
    output logic                   ack
);
    import grad_pkg::*;

    logic         res_valid;
    grad_result_t res;
    grad_result_t head;
    level_t       level;
    logic         overflow;
    logic         kept;
    logic         dropped;
    count_t       kept_cnt;
    count_t       dropped_cnt;
    logic         pop;
    logic         clear;

    mag_cal u_mag_cal (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .pix       (in_pix),
        .res_valid (res_valid),
        .res       (res)
    );

    result_fifo u_result_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (res_valid),
        .din       (res),
        .pop       (pop),
        .clear_ovf (clear),
        .head      (head),
        .level     (level),
        .overflow  (overflow),
        .kept      (kept),
        .dropped   (dropped)
    );

    event_counter u_event_counter (
        .clk         (clk),
        .rst         (rst),
        .kept        (kept),
        .dropped     (dropped),
        .clear       (clear),
        .kept_cnt    (kept_cnt),
        .dropped_cnt (dropped_cnt)
    );

    wb_regs_ctrl u_wb_regs_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_i       (dat_i),
        .dat_o       (dat_o),
        .ack         (ack),
        .head        (head),
        .level       (level),
        .overflow    (overflow),
        .kept_cnt    (kept_cnt),
        .dropped_cnt (dropped_cnt),
        .pop         (pop),
        .clear       (clear)
    );

endmodule

`default_nettype wire

// File: tests/grad_model.svh
`ifndef GRAD_MODEL_SVH
`define GRAD_MODEL_SVH

// floor of the square root, settles one result bit at a time from the top
function automatic int sqrt_floor(int x);
    int r;
    int t;
    r = 0;
    for (int b = 13; b >= 0; b--) begin
        t = r + (1 << b);
        if (t * t <= x) r = t;
    end
    return r;
endfunction

// magnitude with mag_f fraction bits, so the sum is scaled by 4^mag_f
function automatic mag_t expected_mag(cross_t p);
    int dv;
    int dh;
    dv = int'(p.bot) - int'(p.top);
    dh = int'(p.right) - int'(p.left);
    return mag_t'(sqrt_floor((dv * dv + dh * dh) << (2 * mag_f)));
endfunction

// vertical over horizontal in Q4.16, truncated toward zero, clamped
function automatic tan_t expected_tan(cross_t p);
    int num;
    int den;
    int q;
    int tmax;
    int tmin;
    num  = int'(p.bot) - int'(p.top);
    den  = int'(p.right) - int'(p.left);
    tmax = (1 << (tan_w - 1)) - 1;
    tmin = -(1 << (tan_w - 1));
    if (den == 0) begin
        if (num == 0) return '0;
        return (num > 0) ? tan_t'(tmax) : tan_t'(tmin);
    end
    q = ((num < 0 ? -num : num) << tan_f) / (den < 0 ? -den : den);
    if ((num < 0) != (den < 0)) return (q > -tmin - 1) ? tan_t'(tmin) : tan_t'(-q);
    return (q > tmax) ? tan_t'(tmax) : tan_t'(q);
endfunction

`endif

// File: tests/tb_grad.sv
`default_nettype none

module tb_grad;
    timeunit 1ns;
    timeprecision 1ps;

    import grad_pkg::*;

    `include "grad_model.svh"

    localparam int ack_limit  = 20;   // cycles to wait for ack
    localparam int poll_limit = 100;  // status polls before giving up

    logic         clk;
    logic         rst;
    logic         in_valid;
    cross_t       in_pix;
    logic         cyc;
    logic         stb;
    logic         we;
    logic [1:0]   adr;
    logic [31:0]  dat_i;
    logic [31:0]  dat_o;
    logic         ack;

    logic [31:0]  seed = 32'h7e96f705;
    int           value_errs = 0;
    int           other_errs = 0;
    grad_result_t model_q[$];  // what the DUT queue should hold

    grad_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_pix   (in_pix),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_i    (dat_i),
        .dat_o    (dat_o),
        .ack      (ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic cross_t random_bundle();
        cross_t p;
        p.top   = pix_t'(next_rand() >> 24);  // low lcg bits repeat quickly
        p.bot   = pix_t'(next_rand() >> 24);
        p.left  = pix_t'(next_rand() >> 24);
        p.right = pix_t'(next_rand() >> 24);
        return p;
    endfunction

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic abort_run(string msg);
        other_errs++;
        $display("%s", msg);
        finish_run();
    endtask

    task automatic check_mag(string name, mag_t exp, mag_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: mag expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_tan(string name, tan_t exp, tan_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: tan expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_level(string name, level_t exp, level_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: level expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(string name, count_t exp, count_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: count expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: flag expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // caller is always just after a falling edge
    task automatic bus_access(logic wr, logic [1:0] a, logic [31:0] wdata,
                              output logic [31:0] rdata);
        int  n;
        bit  got;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_i = wdata;
        n     = 0;
        got   = 0;
        while (!got && n < ack_limit) begin
            @(negedge clk);
            n++;
            got = (ack === 1'b1);
        end
        if (!got) begin
            abort_run($sformatf("no ack from the bus slave at address %0d", a));
        end else begin
            rdata = dat_o;
            cyc   = 1'b0;
            stb   = 1'b0;
            we    = 1'b0;
            @(negedge clk);  // stb stays low for a cycle
        end
    endtask

    task automatic bus_read(logic [1:0] a, output logic [31:0] rdata);
        bus_access(1'b0, a, 32'd0, rdata);
    endtask

    task automatic bus_write(logic [1:0] a, logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, a, wdata, unused);
    endtask

    task automatic check_status(string name, level_t lvl, logic ovf);
        logic [31:0] d;
        bus_read(reg_status, d);
        check_level(name, lvl, level_t'(d[4:0]));
        check_flag({name, "_overflow"}, ovf, d[8]);
    endtask

    task automatic check_counts(string name, count_t kept, count_t dropped);
        logic [31:0] d;
        bus_read(reg_counts, d);
        check_count({name, "_kept"}, kept, d[15:0]);
        check_count({name, "_dropped"}, dropped, d[31:16]);
    endtask

    task automatic send_bundle(cross_t p);
        grad_result_t r;
        in_valid = 1'b1;
        in_pix   = p;
        r.mag    = expected_mag(p);
        r.tan    = expected_tan(p);
        if (model_q.size() < fifo_depth) model_q.push_back(r);  // else dropped
        @(negedge clk);
    endtask

    task automatic send_random(int n);
        for (int i = 0; i < n; i++) begin
            send_bundle(random_bundle());
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_level(string name, level_t target);
        logic [31:0] d;
        int          tries;
        bit          done;
        tries = 0;
        done  = 0;
        while (!done && tries < poll_limit) begin
            bus_read(reg_status, d);
            done = (level_t'(d[4:0]) == target);
            tries++;
        end
        if (!done) abort_run($sformatf("%s: queue level never reached %0d", name, target));
    endtask

    // both counters together show when every result has left the pipeline
    task automatic wait_events(string name, int total);
        logic [31:0] d;
        int          tries;
        bit          done;
        tries = 0;
        done  = 0;
        while (!done && tries < poll_limit) begin
            bus_read(reg_counts, d);
            done = (int'(d[15:0]) + int'(d[31:16]) == total);
            tries++;
        end
        if (!done) abort_run($sformatf("%s: only part of %0d results arrived", name, total));
    endtask

    task automatic drain_and_check(string name, int n);
        logic [31:0]       d;
        logic [31-tan_w:0] ext;
        grad_result_t      exp;
        for (int i = 0; i < n; i++) begin
            if (model_q.size() == 0) begin
                other_errs++;
                $display("%s: model queue ran empty before the DUT queue", name);
                return;
            end
            exp = model_q.pop_front();
            ext = {(32-tan_w){exp.tan[tan_w-1]}};
            bus_read(reg_mag, d);
            check_mag(name, exp.mag, mag_t'(d));
            bus_read(reg_tan, d);  // pops the entry
            check_tan(name, exp.tan, tan_t'(d));
            if (d[31:tan_w] !== ext) begin
                value_errs++;
                $display("ERR %s: tan upper bits expected %0h, actual %0h",
                         name, ext, d[31:tan_w]);
            end
        end
    endtask

    initial begin
        logic [31:0] d;
        rst      = 1'b0;
        in_valid = 1'b0;
        in_pix   = '0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_i    = '0;
        repeat (5) @(posedge clk);  // five rising edges in reset
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        check_flag("reset_ack", 1'b0, ack);
        check_status("reset_status", 0, 1'b0);
        check_counts("reset_counts", 0, 0);
        bus_read(reg_mag, d);
        check_mag("reset_empty_mag", '0, mag_t'(d));
        bus_read(reg_tan, d);
        check_tan("reset_empty_tan", '0, tan_t'(d));

        send_random(12);
        wait_level("stream", 12);
        drain_and_check("stream", 12);
        check_status("stream_drained", 0, 1'b0);

        // zero horizontal difference, and flat neighbourhoods
        send_bundle(cross_t'{top: 8'd10, bot: 8'd200, left: 8'd77, right: 8'd77});
        send_bundle(cross_t'{top: 8'd200, bot: 8'd10, left: 8'd5, right: 8'd5});
        send_bundle(cross_t'{top: 8'd99, bot: 8'd99, left: 8'd99, right: 8'd99});
        send_bundle(cross_t'{top: 8'd40, bot: 8'd40, left: 8'd250, right: 8'd250});
        send_bundle(cross_t'{top: 8'd0, bot: 8'd255, left: 8'd0, right: 8'd1});
        in_valid = 1'b0;
        wait_level("direction_edges", 5);
        drain_and_check("direction_edges", 5);
        check_status("direction_drained", 0, 1'b0);

        bus_write(reg_status, 32'd0);
        check_counts("pre_overflow", 0, 0);
        send_random(40);  // no reads while streaming
        wait_events("overflow", 40);
        check_status("overflow", 16, 1'b1);
        check_counts("overflow", 16, 24);

        bus_write(reg_status, 32'hffff_ffff);
        check_status("clear", 16, 1'b0);
        check_counts("clear", 0, 0);
        drain_and_check("overflow_order", 16);
        check_status("clear_drained", 0, 1'b0);

        send_random(5);
        wait_level("after_clear", 5);
        drain_and_check("after_clear", 5);
        check_status("after_clear_drained", 0, 1'b0);
        check_counts("after_clear", 5, 0);

        finish_run();
    end

endmodule

`default_nettype wire

// File: files.f
hdl/grad_pkg.sv
hdl/sum_sq_diff.sv
hdl/isqrt.sv
hdl/tan_div.sv
hdl/mag_cal.sv
hdl/result_fifo.sv
hdl/event_counter.sv
hdl/wb_regs_ctrl.sv
hdl/grad_top.sv
+incdir+tests
tests/tb_grad.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       ?= tb_grad
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
